/* hw/mem_pkg.sv */
/*
 * Data memory package
 * Widths, address types, access-size encoding and the lane and row helpers
 * shared by the store and load routers
 */
package mem_pkg;

    localparam int ADDR_W      = 5;
    localparam int BANK_COUNT  = 4;
    localparam int LANE_W      = 8;
    localparam int DATA_W      = 32;
    localparam int OFFSET_W    = $clog2(BANK_COUNT);
    localparam int BANK_ADDR_W = ADDR_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]      byte_addr_t;
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;
    typedef logic [LANE_W-1:0]      lane_t;
    typedef logic [DATA_W-1:0]      data_t;

    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } access_size_e;

    // Bytes moved by one access, zero for SIZE_NONE
    function automatic logic [OFFSET_W:0] size_bytes(access_size_e size);
        case (size)
            SIZE_BYTE: return 3'd1;
            SIZE_HALF: return 3'd2;
            SIZE_WORD: return 3'd4;
            default:   return 3'd0;
        endcase
    endfunction

    // Which byte of the access falls into a given bank
    function automatic logic [OFFSET_W-1:0] lane_index(byte_addr_t addr,
                                                       logic [OFFSET_W-1:0] bank);
        return bank - addr[OFFSET_W-1:0];
    endfunction

    // Banks below the offset hold the bytes that spill into the next row
    function automatic bank_addr_t bank_row(byte_addr_t addr, logic [OFFSET_W-1:0] bank);
        return addr[ADDR_W-1:OFFSET_W] + bank_addr_t'(bank < addr[OFFSET_W-1:0]);
    endfunction

endpackage

/* hw/bank_ram.sv */
/*
 * Byte-wide memory bank
 * Synchronous write, registered read with read-before-write on the same edge
 */
module bank_ram (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_we,
    input  mem_pkg::bank_addr_t i_waddr,
    input  mem_pkg::lane_t      i_wdata,
    input  logic                i_re,
    input  mem_pkg::bank_addr_t i_raddr,
    output mem_pkg::lane_t      o_rdata
);

    import mem_pkg::*;

    lane_t mem [2**BANK_ADDR_W];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Old contents are sampled when a write hits the same row
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

/* hw/store_lane_router.sv */
/*
 * Store lane router
 * Spreads one byte, half or word store over the four byte banks, with the
 * row stepping by one for banks that a misaligned store wraps into
 */
module store_lane_router (
    input  logic                                i_wen,
    input  mem_pkg::byte_addr_t                 i_waddr,
    input  mem_pkg::access_size_e               i_wsize,
    input  mem_pkg::data_t                      i_din,
    output logic [mem_pkg::BANK_COUNT-1:0]      o_bank_we,
    output mem_pkg::bank_addr_t                 o_bank_waddr [mem_pkg::BANK_COUNT],
    output mem_pkg::lane_t                      o_bank_wdata [mem_pkg::BANK_COUNT]
);

    import mem_pkg::*;

    logic [OFFSET_W:0] num_bytes;

    // Zero for SIZE_NONE, which keeps every enable low
    assign num_bytes = size_bytes(i_wsize);

    genvar b;
    generate
        for (b = 0; b < BANK_COUNT; b++) begin : g_lane
            logic [OFFSET_W-1:0] lane_idx;

            assign lane_idx = lane_index(i_waddr, OFFSET_W'(b));

            assign o_bank_we[b]    = i_wen && (lane_idx < num_bytes);
            assign o_bank_waddr[b] = bank_row(i_waddr, OFFSET_W'(b));
            assign o_bank_wdata[b] = i_din[lane_idx*LANE_W +: LANE_W];
        end
    endgenerate

endmodule

/* hw/load_lane_router.sv */
/*
 * Load lane router
 * Issues reads to the banks a load touches, then rotates the bank bytes
 * into result order and zero-extends past the access size
 */
module load_lane_router (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_ren,
    input  mem_pkg::byte_addr_t                 i_raddr,
    input  mem_pkg::access_size_e               i_rsize,
    input  mem_pkg::lane_t                      i_bank_rdata [mem_pkg::BANK_COUNT],
    output logic [mem_pkg::BANK_COUNT-1:0]      o_bank_re,
    output mem_pkg::bank_addr_t                 o_bank_raddr [mem_pkg::BANK_COUNT],
    output mem_pkg::data_t                      o_dout
);

    import mem_pkg::*;

    logic [OFFSET_W:0]   num_bytes;
    logic                load_accept;
    logic [OFFSET_W-1:0] rd_offset;
    access_size_e        rd_size;
    logic [OFFSET_W:0]   rd_bytes;

    assign num_bytes   = size_bytes(i_rsize);
    assign load_accept = i_ren && (i_rsize != SIZE_NONE);

    genvar b;
    generate
        for (b = 0; b < BANK_COUNT; b++) begin : g_req
            logic [OFFSET_W-1:0] lane_idx;

            assign lane_idx        = lane_index(i_raddr, OFFSET_W'(b));
            assign o_bank_re[b]    = i_ren && (lane_idx < num_bytes);
            assign o_bank_raddr[b] = bank_row(i_raddr, OFFSET_W'(b));
        end
    endgenerate

    // Shape of the load now sitting in the bank read registers
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_offset <= '0;
            rd_size   <= SIZE_NONE;
        end else if (load_accept) begin
            rd_offset <= i_raddr[OFFSET_W-1:0];
            rd_size   <= i_rsize;
        end
    end

    assign rd_bytes = size_bytes(rd_size);

    /*
     * Bank outputs are already the pipeline register, so the result is
     * assembled here and stays stable until the next accepted load
     */
    genvar k;
    generate
        for (k = 0; k < BANK_COUNT; k++) begin : g_byte
            logic [OFFSET_W-1:0] src_bank;

            assign src_bank = rd_offset + OFFSET_W'(k);
            assign o_dout[k*LANE_W +: LANE_W] = (k < rd_bytes) ? i_bank_rdata[src_bank] : '0;
        end
    endgenerate

endmodule

/* hw/data_memory.sv */
/*
 * Byte-addressed data memory
 * Four byte banks behind a store router and a load router, one write and
 * one read port, load data one cycle after the read strobe
 */
module data_memory (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_wen,
    input  mem_pkg::byte_addr_t     i_waddr,
    input  mem_pkg::access_size_e   i_wsize,
    input  mem_pkg::data_t          i_din,
    input  logic                    i_ren,
    input  mem_pkg::byte_addr_t     i_raddr,
    input  mem_pkg::access_size_e   i_rsize,
    output mem_pkg::data_t          o_dout
);

    import mem_pkg::*;

    logic [BANK_COUNT-1:0] bank_we;
    bank_addr_t            bank_waddr [BANK_COUNT];
    lane_t                 bank_wdata [BANK_COUNT];

    logic [BANK_COUNT-1:0] bank_re;
    bank_addr_t            bank_raddr [BANK_COUNT];
    lane_t                 bank_rdata [BANK_COUNT];

    store_lane_router u_store_router (
        .i_wen        (i_wen),
        .i_waddr      (i_waddr),
        .i_wsize      (i_wsize),
        .i_din        (i_din),
        .o_bank_we    (bank_we),
        .o_bank_waddr (bank_waddr),
        .o_bank_wdata (bank_wdata)
    );

    load_lane_router u_load_router (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_ren        (i_ren),
        .i_raddr      (i_raddr),
        .i_rsize      (i_rsize),
        .i_bank_rdata (bank_rdata),
        .o_bank_re    (bank_re),
        .o_bank_raddr (bank_raddr),
        .o_dout       (o_dout)
    );

    // Bank n holds every byte whose address is n mod 4
    genvar b;
    generate
        for (b = 0; b < BANK_COUNT; b++) begin : g_bank
            bank_ram u_bank (
                .clk     (clk),
                .i_rst_n (i_rst_n),
                .i_we    (bank_we[b]),
                .i_waddr (bank_waddr[b]),
                .i_wdata (bank_wdata[b]),
                .i_re    (bank_re[b]),
                .i_raddr (bank_raddr[b]),
                .o_rdata (bank_rdata[b])
            );
        end
    endgenerate

endmodule

/* dv/data_memory_props.sv */
/*
 * Data memory assertions
 * Bank write enables against the store strobe and size, and zero
 * extension of byte loads
 */
module data_memory_props (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_wen,
    input  mem_pkg::access_size_e               i_wsize,
    input  logic                                i_ren,
    input  mem_pkg::access_size_e               i_rsize,
    input  logic [mem_pkg::BANK_COUNT-1:0]      i_bank_we,
    input  mem_pkg::data_t                      i_dout
);

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    function automatic int bytes_in(access_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            SIZE_WORD: return 4;
            default:   return 0;
        endcase
    endfunction

    // No lane may be written without an accepted store
    a_we_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        (!i_wen || i_wsize == SIZE_NONE) |-> (i_bank_we == '0))
        else $error("bank write enable set without an accepted store");

    a_we_count: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_wen && i_wsize != SIZE_NONE) |-> ($countones(i_bank_we) == bytes_in(i_wsize)))
        else $error("bank write enable count differs from store size");

    a_byte_zext: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_ren && i_rsize == SIZE_BYTE) |=> (i_dout[31:8] == '0))
        else $error("byte load result not zero extended");

endmodule

bind data_memory data_memory_props u_props (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_wen     (i_wen),
    .i_wsize   (i_wsize),
    .i_ren     (i_ren),
    .i_rsize   (i_rsize),
    .i_bank_we (bank_we),
    .i_dout    (o_dout)
);

/* dv/tb_data_memory.sv */
/*
 * Data memory testbench
 * Directed table of stores and loads, then a random phase checked
 * against a byte-array model of the memory
 */
module tb_data_memory;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int TABLE_LEN  = 27;
    localparam int RAND_COUNT = 200;
    localparam int MEM_BYTES  = 32;

    // Operation bit 1 is a store, bit 0 a load
    localparam logic [1:0] OP_IDLE = 2'b00;
    localparam logic [1:0] OP_LD   = 2'b01;
    localparam logic [1:0] OP_ST   = 2'b10;
    localparam logic [1:0] OP_LS   = 2'b11;

    // exp is o_dout one cycle later, held over stores and SIZE_NONE
    typedef struct packed {
        logic [1:0]   op;
        access_size_e size;
        byte_addr_t   addr;
        data_t        data;
        data_t        exp;
    } step_t;

    logic         clk = 1'b0;
    logic         i_rst_n;
    logic         i_wen;
    byte_addr_t   i_waddr;
    access_size_e i_wsize;
    data_t        i_din;
    logic         i_ren;
    byte_addr_t   i_raddr;
    access_size_e i_rsize;
    data_t        o_dout;

    step_t  steps [$];
    lane_t  ref_mem [MEM_BYTES];
    data_t  ref_dout;
    integer seed;
    int     error_count;
    data_t  pend_exp;
    string  pend_tag;

    data_memory dut (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_wen   (i_wen),
        .i_waddr (i_waddr),
        .i_wsize (i_wsize),
        .i_din   (i_din),
        .i_ren   (i_ren),
        .i_raddr (i_raddr),
        .i_rsize (i_rsize),
        .o_dout  (o_dout)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(3 * (TABLE_LEN + RAND_COUNT + 10) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("TEST FAIL");
        $finish;
    end

    function automatic int bytes_of(access_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            SIZE_WORD: return 4;
            default:   return 0;
        endcase
    endfunction

    task automatic check_value(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] t=%0d ns %s: o_dout %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic add_step(input logic [1:0] op, input access_size_e size,
                            input byte_addr_t addr, input data_t data, input data_t exp);
        step_t s;
        s.op   = op;
        s.size = size;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    // Reference model where loads read before the store of the same cycle
    task automatic model_step(input logic [1:0] op, input access_size_e size,
                              input byte_addr_t addr, input data_t data, output data_t exp);
        int n;
        n   = bytes_of(size);
        exp = ref_dout;
        if (op[0] && n > 0) begin
            exp = '0;
            for (int k = 0; k < n; k++) begin
                exp[8*k +: 8] = ref_mem[(int'(addr) + k) % MEM_BYTES];
            end
            ref_dout = exp;
        end
        if (op[1]) begin
            for (int k = 0; k < n; k++) begin
                ref_mem[(int'(addr) + k) % MEM_BYTES] = data[8*k +: 8];
            end
        end
    endtask

    // Drive one step and check the o_dout left by the step before
    task automatic do_step(input logic [1:0] op, input access_size_e size, input byte_addr_t addr,
                           input data_t data, input data_t exp, input string tag);
        @(posedge clk);
        i_wen   <= op[1];
        i_waddr <= addr;
        i_wsize <= size;
        i_din   <= data;
        i_ren   <= op[0];
        i_raddr <= addr;
        i_rsize <= size;
        @(negedge clk);
        check_value(o_dout, pend_exp, pend_tag);
        pend_exp = exp;
        pend_tag = tag;
    endtask

    task automatic build_table();
        add_step(OP_ST, SIZE_WORD, 5'd0,  32'h4433_2211, 32'h0);
        add_step(OP_LD, SIZE_WORD, 5'd0,  32'h0,         32'h4433_2211);
        add_step(OP_ST, SIZE_WORD, 5'd4,  32'h8877_6655, 32'h4433_2211);
        add_step(OP_ST, SIZE_WORD, 5'd8,  32'hccbb_aa99, 32'h4433_2211);
        // Back-to-back misaligned words
        add_step(OP_LD, SIZE_WORD, 5'd1,  32'h0,         32'h5544_3322);
        add_step(OP_LD, SIZE_WORD, 5'd2,  32'h0,         32'h6655_4433);
        add_step(OP_LD, SIZE_WORD, 5'd3,  32'h0,         32'h7766_5544);
        add_step(OP_LD, SIZE_HALF, 5'd3,  32'h0,         32'h0000_5544);
        add_step(OP_LD, SIZE_HALF, 5'd1,  32'h0,         32'h0000_3322);
        add_step(OP_ST, SIZE_HALF, 5'd7,  32'h0000_e0d0, 32'h0000_3322);
        add_step(OP_LD, SIZE_WORD, 5'd6,  32'h0,         32'haae0_d077);
        // Word at the top wraps to bytes 0 and 1
        add_step(OP_ST, SIZE_WORD, 5'd30, 32'h0403_0201, 32'haae0_d077);
        add_step(OP_LD, SIZE_WORD, 5'd30, 32'h0,         32'h0403_0201);
        add_step(OP_LD, SIZE_WORD, 5'd0,  32'h0,         32'h4433_0403);
        add_step(OP_LD, SIZE_HALF, 5'd31, 32'h0,         32'h0000_0302);
        add_step(OP_ST, SIZE_BYTE, 5'd5,  32'hffff_ff5a, 32'h0000_0302);
        add_step(OP_LD, SIZE_WORD, 5'd4,  32'h0,         32'hd077_5a55);
        add_step(OP_LD, SIZE_BYTE, 5'd7,  32'h0,         32'h0000_00d0);
        // SIZE_NONE strobes leave memory and o_dout alone
        add_step(OP_LD, SIZE_NONE, 5'd0,  32'h0,         32'h0000_00d0);
        add_step(OP_ST, SIZE_NONE, 5'd4,  32'h1234_5678, 32'h0000_00d0);
        add_step(OP_LD, SIZE_WORD, 5'd4,  32'h0,         32'hd077_5a55);
        // Same-cycle load and store return the old bytes
        add_step(OP_LS, SIZE_WORD, 5'd2,  32'hdead_beef, 32'h5a55_4433);
        add_step(OP_LD, SIZE_WORD, 5'd2,  32'h0,         32'hdead_beef);
        add_step(OP_LD, SIZE_WORD, 5'd0,  32'h0,         32'hbeef_0403);
        add_step(OP_LD, SIZE_BYTE, 5'd8,  32'h0,         32'h0000_00e0);
        add_step(OP_LD, SIZE_HALF, 5'd2,  32'h0,         32'h0000_beef);
        add_step(OP_LD, SIZE_BYTE, 5'd31, 32'h0,         32'h0000_0002);
    endtask

    initial begin
        data_t       model_exp;
        logic [31:0] rnd;
        data_t       rdata;

        seed        = 32'h442c_303b;
        error_count = 0;
        pend_exp    = '0;
        pend_tag    = "idle after reset";
        ref_dout    = '0;
        i_rst_n     = 1'b0;
        i_wen       = 1'b0;
        i_waddr     = '0;
        i_wsize     = SIZE_NONE;
        i_din       = '0;
        i_ren       = 1'b0;
        i_raddr     = '0;
        i_rsize     = SIZE_NONE;
        build_table();

        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_value(o_dout, '0, "o_dout after reset");

        foreach (steps[i]) begin
            model_step(steps[i].op, steps[i].size, steps[i].addr, steps[i].data, model_exp);
            do_step(steps[i].op, steps[i].size, steps[i].addr, steps[i].data, steps[i].exp,
                    $sformatf("table step %0d", i));
        end

        // Fill every byte so random loads never see unwritten memory
        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            rdata = $random(seed);
            model_step(OP_ST, SIZE_WORD, byte_addr_t'(w * 4), rdata, model_exp);
            do_step(OP_ST, SIZE_WORD, byte_addr_t'(w * 4), rdata, model_exp, "fill");
        end

        for (int i = 0; i < RAND_COUNT; i++) begin
            rnd   = $random(seed);
            rdata = $random(seed);
            model_step(rnd[1:0], access_size_e'(rnd[3:2]), byte_addr_t'(rnd[8:4]), rdata,
                       model_exp);
            do_step(rnd[1:0], access_size_e'(rnd[3:2]), byte_addr_t'(rnd[8:4]), rdata,
                    model_exp, $sformatf("random step %0d", i));
        end
        do_step(OP_IDLE, SIZE_NONE, '0, '0, ref_dout, "flush");

        $display("Checks done with %0d error(s)", error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
hw/mem_pkg.sv
hw/bank_ram.sv
hw/store_lane_router.sv
hw/load_lane_router.sv
hw/data_memory.sv
dv/data_memory_props.sv
dv/tb_data_memory.sv
